//--- rtl/mmu_tlb.sv
// four-way TLB for the MMU: top level tying the ways to the translation block
// software fills entries through tlbadr/tlbdat, the core translates with xlaten

`timescale 1ns/10ps

module mmu_tlb #(
  parameter int AWID = 32 // logical/physical address width, 40 max
) (
  input  logic            clk_g,
  input  logic            arst_n_i,
  // translation
  input  logic [7:0]      asid_i,    // current address space
  input  logic            umode_i,   // user mode
  input  logic            xlaten_i,  // translate level
  input  logic            we_i,      // access is a write
  input  logic [AWID-1:0] ladr_i,    // data logical address
  input  logic            iacc_i,    // instruction fetch
  input  logic [AWID-1:0] iadr_i,    // fetch address
  output logic [AWID-1:0] padr_o,    // physical address
  output logic [3:0]      acr_o,     // access rights
  output logic            tlbmiss_o,
  // software access
  input  logic            tlben_i,   // access strobe
  input  logic            wrtlb_i,   // write strobe
  input  logic [11:0]     tlbadr_i,  // way and set
  input  logic [63:0]     tlbdat_i,
  output logic [63:0]     tlbdat_o
);
  import tlb_pkg::*;

  xlat_res_t           way_res   [TLB_WAYS]; // lookup result per way
  tlb_word_u           way_rdata [TLB_WAYS]; // software read word per way
  logic [TLB_WAYS-1:0] sw_we;
  logic                lkup_start;
  logic                upd;
  logic                dirty;

  // ==================================================
  // ways
  // ==================================================
  for (genvar w = 0; w < TLB_WAYS; w++) begin : g_way
    tlb_way #(
      .AWID (AWID)
    ) u_way (
      .clk_g        (clk_g),
      .arst_n_i     (arst_n_i),
      .sw_en_i      (tlben_i),
      .sw_we_i      (sw_we[w]),
      .sw_addr_i    (tlbadr_i[TLB_SETS_W-1:0]),
      .sw_wdata_i   (tlbdat_i),
      .sw_rdata_o   (way_rdata[w]),
      .xlaten_i     (xlaten_i),
      .lkup_start_i (lkup_start),
      .ladr_i       (ladr_i),
      .asid_i       (asid_i),
      .upd_i        (upd),
      .dirty_i      (dirty),
      .res_o        (way_res[w])
    );
  end

  // ==================================================
  // translation
  // ==================================================
  tlb_xlat #(
    .AWID (AWID)
  ) u_xlat (
    .clk_g        (clk_g),
    .arst_n_i     (arst_n_i),
    .xlaten_i     (xlaten_i),
    .we_i         (we_i),
    .umode_i      (umode_i),
    .iacc_i       (iacc_i),
    .ladr_i       (ladr_i),
    .iadr_i       (iadr_i),
    .wrtlb_i      (wrtlb_i),
    .tlben_i      (tlben_i),
    .tlbadr_i     (tlbadr_i),
    .way_res_i    (way_res),
    .way_rdata_i  (way_rdata),
    .sw_we_o      (sw_we),
    .lkup_start_o (lkup_start),
    .upd_o        (upd),
    .dirty_o      (dirty),
    .padr_o       (padr_o),
    .acr_o        (acr_o),
    .tlbmiss_o    (tlbmiss_o),
    .tlbdat_o     (tlbdat_o)
  );

endmodule

//--- rtl/tlb_pkg.sv
// shared TLB types and geometry: entry layout, entry word views and lookup result
// imported by every TLB module that touches an entry or a way result

package tlb_pkg;

  // ==================================================
  // geometry
  // ==================================================
  localparam int TLB_WAYS   = 4;  // ways, software picks the one to write
  localparam int TLB_SETS_W = 10; // 1024 sets per way
  localparam int PAGE_W     = 14; // 16 KiB pages
  localparam int TAG_LSB    = 24; // tag starts above the set index

  // way number as carried in tlbadr_i[11:10]
  typedef logic [1:0] way_sel_t;

  // ==================================================
  // entry layout, msb first
  // ==================================================
  typedef struct packed {
    logic [7:0]  asid; // address space id of the mapping
    logic        g;    // global, matches any asid
    logic        d;    // dirty, set by a write hit
    logic        a;    // accessed, set by any hit
    logic        rsvd; // kept as written
    logic [3:0]  acr;  // access rights handed to the core
    logic [15:0] tag;  // logical tag, low AWID-24 bits compared
    logic [31:0] ppn;  // physical page, low AWID-14 bits used
  } tlb_entry_t;

  // one RAM word: software moves it as raw bits, lookup and writeback
  // pick it apart as an entry
  typedef union packed {
    logic [63:0] raw; // tlbdat_i / tlbdat_o view
    tlb_entry_t  ent; // field view for compare and a/d update
  } tlb_word_u;

  // ==================================================
  // per-way lookup result
  // ==================================================
  typedef struct packed {
    logic        hit; // tag and asid (or g) matched
    logic [3:0]  acr; // rights of the matching entry
    logic [31:0] ppn; // page number of the matching entry
  } xlat_res_t;

endpackage

//--- rtl/tlb_way.sv
// one TLB way: entry RAM, tag/asid compare and accessed/dirty writeback
// instanced once per way by the TLB top, driven by the translation block

`timescale 1ns/10ps

module tlb_way #(
  parameter int AWID = 32 // logical/physical address width, 40 max
) (
  input  logic                          clk_g,
  input  logic                          arst_n_i,
  input  logic                          sw_en_i,      // software access enable
  input  logic                          sw_we_i,      // software write, this way only
  input  logic [tlb_pkg::TLB_SETS_W-1:0] sw_addr_i,    // set index from tlbadr_i
  input  tlb_pkg::tlb_word_u            sw_wdata_i,
  output tlb_pkg::tlb_word_u            sw_rdata_o,   // one cycle after sw_en_i
  input  logic                          xlaten_i,     // lookup level
  input  logic                          lkup_start_i, // xlaten_i rising pulse
  input  logic [AWID-1:0]               ladr_i,
  input  logic [7:0]                    asid_i,
  input  logic                          upd_i,        // writeback pulse
  input  logic                          dirty_i,      // lookup was a write
  output tlb_pkg::xlat_res_t            res_o
);
  import tlb_pkg::*;

  tlb_word_u             lk_word; // entry read on port B
  tlb_word_u             wb_word; // same entry with a/d merged in
  logic [TLB_SETS_W-1:0] lk_set;  // set of the current lookup
  logic [TLB_SETS_W-1:0] set_q;   // set kept for writeback
  logic                  tag_eq;
  logic                  asid_ok;
  logic                  hit_q;   // this way matched in the last lookup

  assign lk_set = ladr_i[TAG_LSB-1:PAGE_W]; // bits 23..14

  tlb_way_ram u_ram (
    .clk_g     (clk_g),
    .arst_n_i  (arst_n_i),
    .a_en_i    (sw_en_i),
    .a_we_i    (sw_we_i),
    .a_addr_i  (sw_addr_i),
    .a_wdata_i (sw_wdata_i.raw),
    .a_rdata_o (sw_rdata_o),
    .b_en_i    (xlaten_i | upd_i),          // keep enabled for the writeback cycle
    .b_we_i    (upd_i & hit_q),
    .b_addr_i  (upd_i ? set_q : lk_set),    // writeback goes to the looked-up set
    .b_wdata_i (wb_word.raw),
    .b_rdata_o (lk_word)
  );

  // ==================================================
  // compare
  // ==================================================
  assign tag_eq  = lk_word.ent.tag[AWID-TAG_LSB-1:0] == ladr_i[AWID-1:TAG_LSB];
  assign asid_ok = (lk_word.ent.asid == asid_i) || lk_word.ent.g; // global ignores asid

  assign res_o.hit = tag_eq && asid_ok;
  assign res_o.acr = lk_word.ent.acr;
  assign res_o.ppn = lk_word.ent.ppn;

  // ==================================================
  // accessed / dirty writeback
  // ==================================================
  // d accumulates, a later read hit never clears it
  always_comb begin
    wb_word       = lk_word;
    wb_word.ent.a = 1'b1;
    wb_word.ent.d = lk_word.ent.d | dirty_i;
  end

  always_ff @(posedge clk_g) begin
    if (xlaten_i) set_q <= lk_set; // last set seen while translating
  end

  // cleared as a lookup opens, then follows the fresh compare each cycle;
  // any match counts, including bypassed accesses
  always_ff @(posedge clk_g or negedge arst_n_i) begin
    if (!arst_n_i)         hit_q <= 1'b0;
    else if (lkup_start_i) hit_q <= 1'b0;      // RAM data still stale this cycle
    else if (xlaten_i)     hit_q <= res_o.hit;
  end

endmodule

//--- rtl/tlb_way_ram.sv
// 1024x64 true dual-port entry store for one TLB way, synchronous on both ports
// port A serves software access, port B serves lookup and a/d writeback

`timescale 1ns/10ps

module tlb_way_ram (
  input  logic                          clk_g,
  input  logic                          arst_n_i,
  input  logic                          a_en_i,    // software port enable
  input  logic                          a_we_i,    // software write
  input  logic [tlb_pkg::TLB_SETS_W-1:0] a_addr_i,
  input  logic [63:0]                   a_wdata_i,
  output logic [63:0]                   a_rdata_o, // registered read
  input  logic                          b_en_i,    // lookup port enable
  input  logic                          b_we_i,    // writeback strobe
  input  logic [tlb_pkg::TLB_SETS_W-1:0] b_addr_i,
  input  logic [63:0]                   b_wdata_i,
  output logic [63:0]                   b_rdata_o  // registered read
);
  import tlb_pkg::*;

  logic [63:0] mem [1 << TLB_SETS_W]; // entry array, no reset

  // both write ports land here, same-set collision is left to the caller
  always_ff @(posedge clk_g) begin
    if (a_en_i && a_we_i) mem[a_addr_i] <= a_wdata_i;
    if (b_en_i && b_we_i) mem[b_addr_i] <= b_wdata_i;
  end

  // read before write, old word comes out on a write cycle
  always_ff @(posedge clk_g or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_rdata_o <= '0;
      b_rdata_o <= '0;
    end else begin
      if (a_en_i) a_rdata_o <= mem[a_addr_i]; // hold when idle
      if (b_en_i) b_rdata_o <= mem[b_addr_i]; // held entry feeds writeback
    end
  end

endmodule

//--- rtl/tlb_xlat.sv
// translation block of the TLB: xlaten edge detect, hit priority, output
// registers and the software way decode / read mux shared by all ways

`timescale 1ns/10ps

module tlb_xlat #(
  parameter int AWID = 32 // logical/physical address width, 40 max
) (
  input  logic                         clk_g,
  input  logic                         arst_n_i,
  input  logic                         xlaten_i,     // translate level
  input  logic                         we_i,         // access is a write
  input  logic                         umode_i,      // user mode, else supervisor
  input  logic                         iacc_i,       // instruction fetch
  input  logic [AWID-1:0]              ladr_i,       // data logical address
  input  logic [AWID-1:0]              iadr_i,       // fetch address
  input  logic                         wrtlb_i,      // software write strobe
  input  logic                         tlben_i,      // software access strobe
  input  logic [11:0]                  tlbadr_i,     // way in 11..10, set in 9..0
  input  tlb_pkg::xlat_res_t           way_res_i   [tlb_pkg::TLB_WAYS],
  input  tlb_pkg::tlb_word_u           way_rdata_i [tlb_pkg::TLB_WAYS],
  output logic [tlb_pkg::TLB_WAYS-1:0] sw_we_o,      // one-hot write strobe
  output logic                         lkup_start_o, // xlaten_i rising
  output logic                         upd_o,        // writeback pulse
  output logic                         dirty_o,      // we_i of the lookup
  output logic [AWID-1:0]              padr_o,
  output logic [3:0]                   acr_o,
  output logic                         tlbmiss_o,
  output logic [63:0]                  tlbdat_o
);
  import tlb_pkg::*;

  logic        xlat_q;   // xlaten_i history
  logic        lkup_vld; // RAM data belongs to this lookup
  logic        unmapped; // top 16 MiB, never translated
  logic        any_hit;
  logic [3:0]  sel_acr;
  logic [31:0] sel_ppn;
  way_sel_t    sw_way;
  way_sel_t    rd_way_q; // way of the read in flight

  // ==================================================
  // xlaten edges
  // ==================================================
  assign lkup_start_o = xlaten_i & ~xlat_q;
  assign lkup_vld     = xlaten_i & xlat_q; // second cycle on, RAM read has landed

  always_ff @(posedge clk_g or negedge arst_n_i) begin
    if (!arst_n_i) begin
      xlat_q  <= 1'b0;
      upd_o   <= 1'b0;
      dirty_o <= 1'b0;
    end else begin
      xlat_q <= xlaten_i;
      upd_o  <= xlat_q & ~xlaten_i;    // one cycle, right after the fall
      if (xlaten_i) dirty_o <= we_i;   // frozen once translation ends
    end
  end

  // ==================================================
  // hit select
  // ==================================================
  // walk down so the lowest hitting way is the one left standing
  always_comb begin
    any_hit = 1'b0;
    sel_acr = '0;
    sel_ppn = '0;
    for (int w = TLB_WAYS - 1; w >= 0; w--) begin
      if (way_res_i[w].hit) begin
        any_hit = 1'b1;
        sel_acr = way_res_i[w].acr;
        sel_ppn = way_res_i[w].ppn;
      end
    end
  end

  assign unmapped = &ladr_i[AWID-1:TAG_LSB]; // tag all ones

  // ==================================================
  // output registers
  // ==================================================
  always_ff @(posedge clk_g or negedge arst_n_i) begin
    if (!arst_n_i) begin
      padr_o    <= '0;
      acr_o     <= '0;
      tlbmiss_o <= 1'b0;
    end else if (lkup_vld) begin
      if (iacc_i) begin // fetch side is mapped elsewhere
        padr_o    <= iadr_i;
        acr_o     <= 4'b1111;
        tlbmiss_o <= 1'b0;
      end else if (!umode_i || unmapped) begin
        padr_o    <= ladr_i;
        acr_o     <= 4'b1111;
        tlbmiss_o <= 1'b0;
      end else if (any_hit) begin
        padr_o    <= {sel_ppn[AWID-PAGE_W-1:0], ladr_i[PAGE_W-1:0]};
        acr_o     <= sel_acr;
        tlbmiss_o <= 1'b0;
      end else begin
        tlbmiss_o <= 1'b1; // padr/acr keep the last good translation
      end
    end
  end

  // ==================================================
  // software port
  // ==================================================
  assign sw_way = tlbadr_i[TLB_SETS_W+1:TLB_SETS_W];

  always_comb begin
    for (int w = 0; w < TLB_WAYS; w++) begin
      sw_we_o[w] = wrtlb_i && (sw_way == way_sel_t'(w)); // RAM adds tlben_i
    end
  end

  always_ff @(posedge clk_g or negedge arst_n_i) begin
    if (!arst_n_i)    rd_way_q <= '0;
    else if (tlben_i) rd_way_q <= sw_way; // lines up with the RAM read register
  end

  assign tlbdat_o = way_rdata_i[rd_way_q].raw;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TLB testbench with Verilator.
# Exit status is 0 only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_mmu_tlb \
  -f sim.f \
  -o Vtb_mmu_tlb
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_mmu_tlb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- sim.f
rtl/tlb_pkg.sv
rtl/tlb_way_ram.sv
rtl/tlb_way.sv
rtl/tlb_xlat.sv
rtl/mmu_tlb.sv
test/mmu_tlb_properties.sv
test/tb_mmu_tlb.sv

//--- test/mmu_tlb_properties.sv
// concurrent checks on the TLB top level ports, bound into every mmu_tlb instance
// covers reset state, fetch bypass rights and unknown outputs

`timescale 1ns/10ps

module mmu_tlb_properties #(
  parameter int AWID = 32
) (
  input logic            clk_g,
  input logic            arst_n_i,
  input logic            xlaten_i,
  input logic            iacc_i,
  input logic [AWID-1:0] padr_o,
  input logic [3:0]      acr_o,
  input logic            tlbmiss_o,
  input logic [63:0]     tlbdat_o
);

  // no miss can be flagged while or right after reset
  property miss_low_out_of_reset;
    @(posedge clk_g) !arst_n_i |=> !tlbmiss_o;
  endproperty

  // fetch lookup opens, outputs registered two edges later
  property fetch_full_rights;
    @(posedge clk_g) disable iff (!arst_n_i)
      ($rose(xlaten_i) && iacc_i) |-> ##2 (acr_o == 4'b1111);
  endproperty

  property outputs_known;
    @(posedge clk_g) disable iff (!arst_n_i)
      !$isunknown({padr_o, acr_o, tlbmiss_o, tlbdat_o});
  endproperty

  a_miss_reset : assert property (miss_low_out_of_reset)
    else $error("tlbmiss_o high out of reset");
  a_fetch_acr  : assert property (fetch_full_rights)
    else $error("acr_o not 1111 after a fetch lookup");
  a_known      : assert property (outputs_known)
    else $error("unknown value on a TLB output");

endmodule

bind mmu_tlb mmu_tlb_properties #(
  .AWID (AWID)
) u_props (
  .clk_g     (clk_g),
  .arst_n_i  (arst_n_i),
  .xlaten_i  (xlaten_i),
  .iacc_i    (iacc_i),
  .padr_o    (padr_o),
  .acr_o     (acr_o),
  .tlbmiss_o (tlbmiss_o),
  .tlbdat_o  (tlbdat_o)
);

//--- test/tb_mmu_tlb.sv
// testbench for the four-way TLB: fills entries, reads them back and checks lookups
// against a shadow copy of the ways and a reference translation function

`timescale 1ns/10ps

module tb_mmu_tlb;
  import tlb_pkg::*;

  localparam int AWID       = 32;
  localparam int NSETS      = 32;   // sets exercised per way
  localparam int MAX_CYCLES = 2000; // tests take about 1000 cycles

  // expected outputs of one lookup
  typedef struct packed {
    logic [AWID-1:0] padr;
    logic [3:0]      acr;
    logic            miss;
  } xlat_exp_t;

  logic            clk_g;
  logic            arst_n_i;
  logic [7:0]      asid_i;
  logic            umode_i;
  logic            xlaten_i;
  logic            we_i;
  logic [AWID-1:0] ladr_i;
  logic            iacc_i;
  logic [AWID-1:0] iadr_i;
  logic [AWID-1:0] padr_o;
  logic [3:0]      acr_o;
  logic            tlbmiss_o;
  logic            tlben_i;
  logic            wrtlb_i;
  logic [11:0]     tlbadr_i;
  logic [63:0]     tlbdat_i;
  logic [63:0]     tlbdat_o;

  tlb_entry_t  shadow [TLB_WAYS][1 << TLB_SETS_W]; // software view of every way
  logic [9:0]  sets [NSETS];
  logic [31:0] seed;
  xlat_exp_t   exp_x;     // also holds the last translation for misses
  logic [63:0] exp_word;
  logic [1:0]  chk_kind;  // 1 lookup outputs, 2 software readback
  int          cycles;

  mmu_tlb #(
    .AWID (AWID)
  ) dut (
    .clk_g     (clk_g),
    .arst_n_i  (arst_n_i),
    .asid_i    (asid_i),
    .umode_i   (umode_i),
    .xlaten_i  (xlaten_i),
    .we_i      (we_i),
    .ladr_i    (ladr_i),
    .iacc_i    (iacc_i),
    .iadr_i    (iadr_i),
    .padr_o    (padr_o),
    .acr_o     (acr_o),
    .tlbmiss_o (tlbmiss_o),
    .tlben_i   (tlben_i),
    .wrtlb_i   (wrtlb_i),
    .tlbadr_i  (tlbadr_i),
    .tlbdat_i  (tlbdat_i),
    .tlbdat_o  (tlbdat_o)
  );

  initial begin
    clk_g = 1'b0;
    forever #50 clk_g = ~clk_g; // 100 ns period
  end

  // ==================================================
  // stimulus helpers and reference model
  // ==================================================
  function automatic logic [31:0] rnd();
    seed = seed * 32'd1664525 + 32'd1013904223; // LCG step
    return seed;
  endfunction

  function automatic tlb_entry_t rand_entry();
    tlb_entry_t e;
    e = {rnd(), rnd()};
    e.g = (rnd() % 4 == 0);                    // one entry in four is global
    if (e.tag[7:0] == 8'hff) e.tag[7:0] = 8'hfe; // keep out of the unmapped region
    return e;
  endfunction

  function automatic logic entry_hits(tlb_entry_t e, logic [7:0] asid, logic [AWID-1:0] adr);
    return (e.tag[AWID-TAG_LSB-1:0] == adr[AWID-1:TAG_LSB]) && ((e.asid == asid) || e.g);
  endfunction

  function automatic xlat_exp_t ref_xlat(logic um, logic [7:0] asid, logic [AWID-1:0] ladr,
                                         logic ia, logic [AWID-1:0] iadr, xlat_exp_t prev);
    xlat_exp_t  r;
    logic       found;
    logic [9:0] s;
    r     = prev;
    r.miss = 1'b1;  // padr/acr stay from the previous lookup
    found = 1'b0;
    s     = ladr[TAG_LSB-1:PAGE_W];
    if (ia) begin
      r.padr = iadr;
      r.acr  = 4'hf;
      r.miss = 1'b0;
    end else if (!um || (ladr[AWID-1:TAG_LSB] == '1)) begin
      r.padr = ladr;
      r.acr  = 4'hf;
      r.miss = 1'b0;
    end else begin
      for (int w = 0; w < TLB_WAYS; w++) begin
        if (!found && entry_hits(shadow[w][s], asid, ladr)) begin // lowest way wins
          found  = 1'b1;
          r.padr = {shadow[w][s].ppn[AWID-PAGE_W-1:0], ladr[PAGE_W-1:0]};
          r.acr  = shadow[w][s].acr;
          r.miss = 1'b0;
        end
      end
    end
    return r;
  endfunction

  // every way whose entry matched marks it accessed, dirty on a write
  task automatic apply_writeback(input logic [7:0] asid, input logic [AWID-1:0] ladr,
                                 input logic we);
    logic [9:0] s;
    s = ladr[TAG_LSB-1:PAGE_W];
    for (int w = 0; w < TLB_WAYS; w++) begin
      if (entry_hits(shadow[w][s], asid, ladr)) begin
        shadow[w][s].a = 1'b1;
        shadow[w][s].d = shadow[w][s].d | we;
      end
    end
  endtask

  task automatic sw_write(input logic [1:0] w, input logic [9:0] s, input tlb_entry_t e);
    @(posedge clk_g);
    tlben_i  <= 1'b1;
    wrtlb_i  <= 1'b1;
    tlbadr_i <= {w, s};
    tlbdat_i <= e;
    shadow[w][s] = e;
    @(posedge clk_g);
    tlben_i <= 1'b0;
    wrtlb_i <= 1'b0;
  endtask

  task automatic sw_read(input logic [1:0] w, input logic [9:0] s);
    @(posedge clk_g);
    tlben_i  <= 1'b1;
    wrtlb_i  <= 1'b0;
    tlbadr_i <= {w, s};
    @(posedge clk_g);
    tlben_i  <= 1'b0;
    exp_word = shadow[w][s];
    chk_kind <= 2'd2; // word is on tlbdat_o after this edge
    @(posedge clk_g);
    chk_kind <= 2'd0;
  endtask

  task automatic lookup(input logic um, input logic [7:0] asid, input logic [AWID-1:0] ladr,
                        input logic ia, input logic [AWID-1:0] iadr, input logic we);
    @(posedge clk_g);
    xlaten_i <= 1'b1;
    umode_i  <= um;
    asid_i   <= asid;
    ladr_i   <= ladr;
    iacc_i   <= ia;
    iadr_i   <= iadr;
    we_i     <= we;
    repeat (2) @(posedge clk_g); // RAM read, then output registers
    exp_x = ref_xlat(um, asid, ladr, ia, iadr, exp_x);
    chk_kind <= 2'd1;
    @(posedge clk_g);
    chk_kind <= 2'd0;
    xlaten_i <= 1'b0;
    we_i     <= 1'b0;
    ladr_i   <= ~ladr; // writeback has to go to the set kept from the lookup
    apply_writeback(asid, ladr, we);
    repeat (2) @(posedge clk_g); // let the a/d writeback land
  endtask

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // ==================================================
  // compare and timeout
  // ==================================================
  always @(negedge clk_g) begin
    if (chk_kind == 2'd1) begin
      check("padr_o", 64'(padr_o), 64'(exp_x.padr));
      check("acr_o", 64'(acr_o), 64'(exp_x.acr));
      check("tlbmiss_o", 64'(tlbmiss_o), 64'(exp_x.miss));
    end else if (chk_kind == 2'd2) begin
      check("tlbdat_o", tlbdat_o, exp_word);
    end
  end

  always @(posedge clk_g) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    tlb_entry_t e;
    logic [7:0] mt;
    logic [9:0] s;
    seed     = 32'd28;
    cycles   = 0;
    chk_kind = 2'd0;
    exp_x    = '0;   // output registers reset to zero
    exp_word = '0;
    arst_n_i = 1'b0;
    asid_i   = '0;
    umode_i  = 1'b0;
    xlaten_i = 1'b0;
    we_i     = 1'b0;
    ladr_i   = '0;
    iacc_i   = 1'b0;
    iadr_i   = '0;
    tlben_i  = 1'b0;
    wrtlb_i  = 1'b0;
    tlbadr_i = '0;
    tlbdat_i = '0;
    repeat (5) @(posedge clk_g);
    arst_n_i <= 1'b1;

    // fill all ways at 32 spread sets, then read everything back
    for (int k = 0; k < NSETS; k++) sets[k] = 10'(k * 32) + 10'(rnd() % 32);
    for (int k = 0; k < NSETS; k++) begin
      for (int w = 0; w < TLB_WAYS; w++) sw_write(2'(w), sets[k], rand_entry());
    end
    for (int k = 0; k < NSETS; k++) begin
      for (int w = 0; w < TLB_WAYS; w++) sw_read(2'(w), sets[k]);
    end

    // bypass: supervisor, unmapped region, instruction fetch
    e = shadow[0][sets[0]];
    lookup(1'b0, e.asid, {e.tag[7:0], sets[0], 14'(rnd())}, 1'b0, '0, 1'b0);
    lookup(1'b1, e.asid, {8'hff, sets[1], 14'(rnd())}, 1'b0, '0, 1'b0);
    lookup(1'b1, e.asid, {e.tag[7:0], sets[2], 14'(rnd())}, 1'b1, rnd(), 1'b0);

    // user hits, one per set, rotating through the ways
    for (int k = 0; k < NSETS; k++) begin
      e = shadow[k % TLB_WAYS][sets[k]];
      lookup(1'b1, e.g ? 8'(rnd()) : e.asid, {e.tag[7:0], sets[k], 14'(rnd())}, 1'b0, '0,
             1'b0);
    end

    // two ways match, way 0 must win over way 2
    s = sets[3];
    e = rand_entry();
    e.g = 1'b1;
    sw_write(2'd2, s, e);
    e.ppn = ~e.ppn;
    e.acr = ~e.acr;
    sw_write(2'd0, s, e);
    lookup(1'b1, 8'(rnd()), {e.tag[7:0], s, 14'(rnd())}, 1'b0, '0, 1'b0);

    // misses on a wrong tag, each after a good hit
    for (int k = 4; k < 8; k++) begin
      e = shadow[1][sets[k]];
      lookup(1'b1, e.g ? 8'h00 : e.asid, {e.tag[7:0], sets[k], 14'(rnd())}, 1'b0, '0, 1'b0);
      mt = e.tag[7:0] + 8'd1;
      if (mt == 8'hff) mt = 8'h00;
      lookup(1'b1, e.asid, {mt, sets[k], 14'(rnd())}, 1'b0, '0, 1'b0);
      // each bypass kind once right after a miss, tlbmiss_o must drop
      if (k == 4) lookup(1'b0, e.asid, {mt, sets[k], 14'(rnd())}, 1'b0, '0, 1'b0);
      if (k == 5) lookup(1'b1, e.asid, {8'hff, sets[k], 14'(rnd())}, 1'b0, '0, 1'b0);
      if (k == 6) lookup(1'b1, e.asid, {mt, sets[k], 14'(rnd())}, 1'b1, rnd(), 1'b0);
    end

    // miss on a wrong asid with g clear
    e = rand_entry();
    e.g = 1'b0;
    sw_write(2'd3, sets[8], e);
    lookup(1'b1, e.asid ^ 8'h5a, {e.tag[7:0], sets[8], 14'(rnd())}, 1'b0, '0, 1'b0);

    // write hit sets a and d
    e = rand_entry();
    e.a = 1'b0;
    e.d = 1'b0;
    sw_write(2'd1, sets[10], e);
    lookup(1'b1, e.asid, {e.tag[7:0], sets[10], 14'(rnd())}, 1'b0, '0, 1'b1);
    sw_read(2'd1, sets[10]);

    // read hit sets a and leaves a set d alone
    e = rand_entry();
    e.a = 1'b0;
    e.d = 1'b1;
    sw_write(2'd2, sets[11], e);
    lookup(1'b1, e.asid, {e.tag[7:0], sets[11], 14'(rnd())}, 1'b0, '0, 1'b0);
    sw_read(2'd2, sets[11]);

    repeat (2) @(posedge clk_g);
    $display("Verification passed");
    $finish;
  end

endmodule
